//--- hdl/swi_cfg.svh
/* Build-time sizes of the stack CPU, shared by the packages and the RTL.
   Include wherever a width, the memory depth or the stack layout is needed */
`ifndef SWI_CFG_SVH
`define SWI_CFG_SVH

// Data path and byte address width
`define SWI_XLEN 32

// Unified memory depth in 32-bit words
`define SWI_MEM_WORDS 256

// SP after reset, the last word of memory
`define SWI_SP_INIT ((`SWI_MEM_WORDS * 4) - 4)

`define SWI_STACK_STEP 8  // Bytes moved per push or pop

`endif

//--- hdl/swi_isa_pkg.sv
/* Instruction-set types: opcode values and the decoded-instruction struct
   handed from the decoder to control, ALU and writeback */
`include "swi_cfg.svh"

package swi_isa_pkg;

  // Swieros opcode numbers of the supported subset
  typedef enum logic [7:0] {
    OP_HALT = 8'd0,   OP_ENT  = 8'd1,   OP_LEV  = 8'd2,   OP_JMP  = 8'd3,
    OP_JSR  = 8'd5,   OP_LL   = 8'd14,  OP_LG   = 8'd21,  OP_LI   = 8'd35,
    OP_LHI  = 8'd36,  OP_LBL  = 8'd38,  OP_LBI  = 8'd59,  OP_LBA  = 8'd62,
    OP_SL   = 8'd64,  OP_SG   = 8'd69,
    OP_ADD  = 8'd83,  OP_ADDI = 8'd84,  OP_SUB  = 8'd86,  OP_SUBI = 8'd87,
    OP_MUL  = 8'd89,  OP_MULI = 8'd90,  OP_AND  = 8'd104, OP_ANDI = 8'd105,
    OP_OR   = 8'd107, OP_ORI  = 8'd108, OP_XOR  = 8'd110, OP_XORI = 8'd111,
    OP_SHL  = 8'd113, OP_SHLI = 8'd114, OP_SHR  = 8'd116, OP_SHRI = 8'd117,
    OP_SRU  = 8'd119, OP_SRUI = 8'd120,
    OP_EQ   = 8'd122, OP_NE   = 8'd124, OP_LT   = 8'd126, OP_LTU  = 8'd127,
    OP_GE   = 8'd129, OP_GEU  = 8'd130,
    OP_BZ   = 8'd132, OP_BNZ  = 8'd134, OP_BE   = 8'd136, OP_BNE  = 8'd138,
    OP_BLT  = 8'd140, OP_BGE  = 8'd143,
    OP_BOUT = 8'd154, OP_NOP  = 8'd155, OP_PSHA = 8'd157, OP_PSHI = 8'd158,
    OP_PSHB = 8'd160, OP_POPB = 8'd161, OP_POPA = 8'd163, OP_LCA  = 8'd173,
    OP_PUTC = 8'd240  // Console character out
  } swi_opcode_e;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_MUL, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SHL, ALU_SHR, ALU_SRU,                              // SHR is arithmetic
    ALU_EQ, ALU_NE, ALU_LT, ALU_LTU, ALU_GE, ALU_GEU,
    ALU_PASS,                                               // Second operand through
    ALU_LHI                                                 // {A[7:0], imm[23:0]}
  } swi_alu_op_e;

  typedef enum logic [1:0] {OPND_B, OPND_IMM, OPND_MEM} swi_operand_e;

  typedef enum logic [2:0] {DST_NONE, DST_A, DST_B, DST_C, DST_SP, DST_PC} swi_dest_e;

  typedef enum logic [1:0] {MEM_NONE, MEM_READ, MEM_WRITE, MEM_PUSH} swi_mem_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_ALWAYS, BR_Z, BR_NZ, BR_EQ, BR_NE, BR_LT, BR_GE
  } swi_branch_e;

  typedef enum logic {BASE_SP, BASE_PC} swi_base_e;

  typedef struct packed {
    swi_opcode_e          opcode;
    logic [`SWI_XLEN-1:0] imm;        // Sign-extended IR[31:8]
    swi_alu_op_e          alu_op;
    swi_operand_e         operand;
    swi_dest_e            dest;
    swi_mem_e             mem;
    swi_branch_e          branch;
    swi_base_e            base;       // Address base for loads and stores
    logic                 illegal;
    logic                 halt;
    logic                 out_a;      // PUTC
    logic                 out_b;      // BOUT
    logic                 stack_adj;  // ENT, push, pop and LEV move SP
  } swi_decoded_t;

endpackage

//--- hdl/swi_mach_pkg.sv
/* Machine types: sequencer states, the CPU memory request
   and the testbench load port */
`include "swi_cfg.svh"

package swi_mach_pkg;

  localparam int MEM_AW = $clog2(`SWI_MEM_WORDS);  // Word index width

  typedef enum logic [2:0] {
    ST_IDLE, ST_FETCH, ST_DECODE, ST_EXEC1, ST_MEM_WAIT, ST_EXEC2, ST_HALT
  } swi_state_e;

  // Read data comes back one cycle later, so no response struct
  typedef struct packed {
    logic                 valid;
    logic                 write;
    logic [`SWI_XLEN-1:0] addr;   // Byte address, low two bits ignored
    logic [`SWI_XLEN-1:0] wdata;
  } swi_mem_req_t;

  typedef struct packed {
    logic                 stb;
    logic [MEM_AW-1:0]    addr;   // Word index
    logic [`SWI_XLEN-1:0] data;
  } swi_load_t;

endpackage

//--- hdl/swi_decoder.sv
/* Combinational instruction decoder. Splits the IR into the decoded struct;
   anything outside the supported opcode set comes out flagged illegal */
`include "swi_cfg.svh"

module swi_decoder import swi_isa_pkg::*; (
  input  logic [`SWI_XLEN-1:0] i_instr,
  output swi_decoded_t         o_dec
);

  logic arith;  // Plain ALU op into A

  always_comb begin
    o_dec         = '0;
    o_dec.opcode  = swi_opcode_e'(i_instr[7:0]);
    o_dec.imm     = {{8{i_instr[31]}}, i_instr[31:8]};
    o_dec.alu_op  = ALU_PASS;
    o_dec.operand = OPND_B;
    o_dec.dest    = DST_NONE;
    o_dec.mem     = MEM_NONE;
    o_dec.branch  = BR_NONE;
    o_dec.base    = BASE_SP;
    arith         = 1'b1;

    // ALU function, register and immediate forms share it
    case (i_instr[7:0])
      OP_ADD, OP_ADDI: o_dec.alu_op = ALU_ADD;
      OP_SUB, OP_SUBI: o_dec.alu_op = ALU_SUB;
      OP_MUL, OP_MULI: o_dec.alu_op = ALU_MUL;
      OP_AND, OP_ANDI: o_dec.alu_op = ALU_AND;
      OP_OR,  OP_ORI:  o_dec.alu_op = ALU_OR;
      OP_XOR, OP_XORI: o_dec.alu_op = ALU_XOR;
      OP_SHL, OP_SHLI: o_dec.alu_op = ALU_SHL;
      OP_SHR, OP_SHRI: o_dec.alu_op = ALU_SHR;
      OP_SRU, OP_SRUI: o_dec.alu_op = ALU_SRU;
      OP_EQ:           o_dec.alu_op = ALU_EQ;   // Compares only in register form
      OP_NE:           o_dec.alu_op = ALU_NE;
      OP_LT:           o_dec.alu_op = ALU_LT;
      OP_LTU:          o_dec.alu_op = ALU_LTU;
      OP_GE:           o_dec.alu_op = ALU_GE;
      OP_GEU:          o_dec.alu_op = ALU_GEU;
      default:         arith = 1'b0;
    endcase
    if (arith) o_dec.dest = DST_A;

    case (i_instr[7:0])
      OP_ADDI, OP_SUBI, OP_MULI, OP_ANDI, OP_ORI, OP_XORI,
      OP_SHLI, OP_SHRI, OP_SRUI: o_dec.operand = OPND_IMM;
      // Register moves
      OP_LI:  begin o_dec.operand = OPND_IMM; o_dec.dest = DST_A; end
      OP_LHI: begin o_dec.alu_op = ALU_LHI; o_dec.operand = OPND_IMM; o_dec.dest = DST_A; end
      OP_LBI: begin o_dec.operand = OPND_IMM; o_dec.dest = DST_B; end
      OP_LBA, OP_LCA: begin
        o_dec.alu_op  = ALU_ADD;                  // A + 0
        o_dec.operand = OPND_IMM;
        o_dec.imm     = '0;
        o_dec.dest    = (i_instr[7:0] == OP_LBA) ? DST_B : DST_C;
      end
      // Branches, target is PC + imm
      OP_BZ:  o_dec.branch = BR_Z;
      OP_BNZ: o_dec.branch = BR_NZ;
      OP_BE:  o_dec.branch = BR_EQ;
      OP_BNE: o_dec.branch = BR_NE;
      OP_BLT: o_dec.branch = BR_LT;
      OP_BGE: o_dec.branch = BR_GE;
      OP_JMP: o_dec.branch = BR_ALWAYS;
      OP_JSR: begin
        o_dec.branch    = BR_ALWAYS;
        o_dec.mem       = MEM_PUSH;               // Return address onto the stack
        o_dec.stack_adj = 1'b1;
      end
      // Loads and stores
      OP_LL, OP_LG, OP_LBL: begin
        o_dec.mem     = MEM_READ;
        o_dec.operand = OPND_MEM;
        o_dec.base    = (i_instr[7:0] == OP_LG) ? BASE_PC : BASE_SP;
        o_dec.dest    = (i_instr[7:0] == OP_LBL) ? DST_B : DST_A;
      end
      OP_SL: o_dec.mem = MEM_WRITE;
      OP_SG: begin o_dec.mem = MEM_WRITE; o_dec.base = BASE_PC; end
      // Stack
      OP_PSHA, OP_PSHB, OP_PSHI: begin o_dec.mem = MEM_PUSH; o_dec.stack_adj = 1'b1; end
      OP_POPA, OP_POPB: begin
        o_dec.mem       = MEM_READ;
        o_dec.operand   = OPND_MEM;
        o_dec.imm       = '0;                     // Read at SP itself
        o_dec.stack_adj = 1'b1;
        o_dec.dest      = (i_instr[7:0] == OP_POPA) ? DST_A : DST_B;
      end
      OP_ENT: o_dec.stack_adj = 1'b1;
      OP_LEV: begin
        o_dec.mem       = MEM_READ;
        o_dec.operand   = OPND_MEM;
        o_dec.stack_adj = 1'b1;
        o_dec.dest      = DST_PC;                 // Return address from SP + imm
      end
      OP_PUTC: o_dec.out_a = 1'b1;
      OP_BOUT: o_dec.out_b = 1'b1;
      OP_HALT: o_dec.halt  = 1'b1;
      OP_NOP:  ;
      default: o_dec.illegal = !arith;
    endcase
  end

endmodule

//--- hdl/swi_alu.sv
/* Accumulator ALU, branch condition and effective address.
   Purely combinational, fed from the register file and the decoder */
`include "swi_cfg.svh"

module swi_alu import swi_isa_pkg::*; (
  input  swi_decoded_t         i_dec,
  input  logic [`SWI_XLEN-1:0] i_a,
  input  logic [`SWI_XLEN-1:0] i_b,
  input  logic [`SWI_XLEN-1:0] i_sp,
  input  logic [`SWI_XLEN-1:0] i_pc,
  input  logic [`SWI_XLEN-1:0] i_mem_data,
  output logic [`SWI_XLEN-1:0] o_result,
  output logic                 o_taken,
  output logic [`SWI_XLEN-1:0] o_addr
);

  localparam int XLEN = `SWI_XLEN;
  localparam logic [XLEN-1:0] STEP = `SWI_STACK_STEP;

  logic [XLEN-1:0] op2;    // Second operand
  logic [4:0]      shamt;  // Only the low bits count

  always_comb begin
    case (i_dec.operand)
      OPND_IMM: op2 = i_dec.imm;
      OPND_MEM: op2 = i_mem_data;
      default:  op2 = i_b;
    endcase
  end

  assign shamt = op2[4:0];

  always_comb begin
    case (i_dec.alu_op)
      ALU_ADD: o_result = i_a + op2;
      ALU_SUB: o_result = i_a - op2;
      ALU_MUL: o_result = i_a * op2;            // Low word of the product
      ALU_AND: o_result = i_a & op2;
      ALU_OR:  o_result = i_a | op2;
      ALU_XOR: o_result = i_a ^ op2;
      ALU_SHL: o_result = i_a << shamt;
      ALU_SHR: o_result = $signed(i_a) >>> shamt; // Sign fill
      ALU_SRU: o_result = i_a >> shamt;
      ALU_EQ:  o_result = XLEN'(i_a == op2);
      ALU_NE:  o_result = XLEN'(i_a != op2);
      ALU_LT:  o_result = XLEN'($signed(i_a) < $signed(op2));
      ALU_LTU: o_result = XLEN'(i_a < op2);
      ALU_GE:  o_result = XLEN'($signed(i_a) >= $signed(op2));
      ALU_GEU: o_result = XLEN'(i_a >= op2);
      ALU_LHI: o_result = {i_a[7:0], op2[23:0]};
      default: o_result = op2;                  // PASS
    endcase
  end

  always_comb begin
    case (i_dec.branch)
      BR_ALWAYS: o_taken = 1'b1;
      BR_Z:      o_taken = (i_a == '0);
      BR_NZ:     o_taken = (i_a != '0);
      BR_EQ:     o_taken = (i_a == i_b);
      BR_NE:     o_taken = (i_a != i_b);
      BR_LT:     o_taken = ($signed(i_a) < $signed(i_b));
      BR_GE:     o_taken = ($signed(i_a) >= $signed(i_b));
      default:   o_taken = 1'b0;
    endcase
  end

  // Pushes pre-decrement, everything else is base + imm
  assign o_addr = (i_dec.mem == MEM_PUSH) ? i_sp - STEP :
                  ((i_dec.base == BASE_PC) ? i_pc : i_sp) + i_dec.imm;

endmodule

//--- hdl/swi_control.sv
/* Fetch/decode/execute sequencer. Drives the CPU memory port and gives
   writeback its one-cycle commit enables */
`include "swi_cfg.svh"

module swi_control
  import swi_isa_pkg::*;
  import swi_mach_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_arst_n,
  input  logic                 i_start,    // Taken in IDLE only
  input  swi_decoded_t         i_dec,
  input  logic [`SWI_XLEN-1:0] i_addr,     // Effective address from the ALU
  input  logic [`SWI_XLEN-1:0] i_pc,
  input  logic [`SWI_XLEN-1:0] i_a,
  input  logic [`SWI_XLEN-1:0] i_b,
  output swi_mem_req_t         o_mem_req,
  output logic                 o_capture,  // IR load, PC + 4
  output logic                 o_exec1,
  output logic                 o_exec2,
  output logic                 o_halted,
  output logic                 o_fault
);

  swi_state_e           state;
  swi_mem_req_t         req_q;   // Data access, live during MEM_WAIT
  logic [`SWI_XLEN-1:0] wdata;

  // Store and push data source
  always_comb begin
    case (i_dec.opcode)
      OP_PSHB: wdata = i_b;
      OP_PSHI: wdata = i_dec.imm;
      OP_JSR:  wdata = i_pc;     // Already points past the JSR
      default: wdata = i_a;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state   <= ST_IDLE;
      req_q   <= '0;
      o_fault <= 1'b0;
    end else begin
      req_q.valid <= 1'b0;       // One cycle only
      case (state)
        ST_IDLE:   if (i_start) state <= ST_FETCH;
        ST_FETCH:  state <= ST_DECODE;
        ST_DECODE: state <= ST_EXEC1;
        ST_EXEC1: begin
          if (i_dec.illegal || i_dec.halt) begin
            state   <= ST_HALT;
            o_fault <= i_dec.illegal;
          end else if (i_dec.mem != MEM_NONE) begin
            state <= ST_MEM_WAIT;
            req_q <= '{valid: 1'b1, write: (i_dec.mem != MEM_READ),
                       addr: i_addr, wdata: wdata};
          end else begin
            state <= ST_FETCH;
          end
        end
        // Read data lands in EXEC2, writes are done here
        ST_MEM_WAIT: state <= (i_dec.mem == MEM_READ) ? ST_EXEC2 : ST_FETCH;
        ST_EXEC2:    state <= ST_FETCH;
        default:     ;           // HALT until reset
      endcase
    end
  end

  // Instruction fetch goes straight out, data accesses come from req_q
  always_comb begin
    o_mem_req = req_q;
    if (state == ST_FETCH) begin
      o_mem_req.valid = 1'b1;
      o_mem_req.write = 1'b0;
      o_mem_req.addr  = i_pc;
    end
  end

  assign o_capture = (state == ST_DECODE);
  assign o_exec1   = (state == ST_EXEC1);
  assign o_exec2   = (state == ST_EXEC2);
  assign o_halted  = (state == ST_HALT);

endmodule

//--- hdl/swi_writeback.sv
/* Architectural registers IR, A, B, SP and PC plus the output strobe.
   Updated on the commit enables from control */
`include "swi_cfg.svh"

module swi_writeback import swi_isa_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_arst_n,
  input  logic                 i_start,
  input  logic [`SWI_XLEN-1:0] i_entry_pc,
  input  logic                 i_capture,
  input  logic                 i_exec1,
  input  logic                 i_exec2,
  input  swi_decoded_t         i_dec,
  input  logic [`SWI_XLEN-1:0] i_mem_data,  // Fetched word in DECODE
  input  logic [`SWI_XLEN-1:0] i_result,
  input  logic                 i_taken,
  output logic [`SWI_XLEN-1:0] o_instr,
  output logic [`SWI_XLEN-1:0] o_a,
  output logic [`SWI_XLEN-1:0] o_b,
  output logic [`SWI_XLEN-1:0] o_sp,
  output logic [`SWI_XLEN-1:0] o_pc,
  output logic                 o_out_stb,
  output logic [7:0]           o_out_data
);

  localparam int XLEN = `SWI_XLEN;
  localparam logic [XLEN-1:0] SP_INIT = `SWI_SP_INIT;
  localparam logic [XLEN-1:0] STEP    = `SWI_STACK_STEP;

  logic [XLEN-1:0] sp_adj;
  logic            wr_en;   // Destination write this cycle

  // SP delta: push -8, pop and LEV imm + 8 (pops carry imm 0), ENT imm
  always_comb begin
    case (i_dec.mem)
      MEM_PUSH: sp_adj = -STEP;
      MEM_READ: sp_adj = i_dec.imm + STEP;
      default:  sp_adj = i_dec.imm;
    endcase
  end

  // Memory reads commit after the data arrives
  assign wr_en = (i_exec1 && (i_dec.mem == MEM_NONE)) || i_exec2;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_instr    <= '0;
      o_a        <= '0;
      o_b        <= '0;
      o_sp       <= SP_INIT;
      o_pc       <= '0;
      o_out_stb  <= 1'b0;
      o_out_data <= '0;
    end else begin
      o_out_stb <= 1'b0;
      if (i_start) o_pc <= i_entry_pc;  // Pulsed only while idle
      if (i_capture) begin
        o_instr <= i_mem_data;
        o_pc    <= o_pc + 4;
      end
      if (i_exec1) begin
        if (i_taken) o_pc <= o_pc + i_dec.imm;
        if (i_dec.stack_adj) o_sp <= o_sp + sp_adj;
        if (i_dec.out_a || i_dec.out_b) begin
          o_out_stb  <= 1'b1;
          o_out_data <= i_dec.out_a ? o_a[7:0] : o_b[7:0];
        end
      end
      if (wr_en) begin
        case (i_dec.dest)
          DST_A:   o_a  <= i_result;
          DST_B:   o_b  <= i_result;
          DST_PC:  o_pc <= i_result;    // LEV return
          default: ;
        endcase
      end
    end
  end

endmodule

//--- hdl/swi_ram.sv
/* Unified word memory, registered read. The load port fills it from the
   testbench and wins over a CPU write in the same cycle */
`include "swi_cfg.svh"

module swi_ram import swi_mach_pkg::*; (
  input  logic                 i_clk,
  input  swi_load_t            i_load,
  input  swi_mem_req_t         i_req,
  output logic [`SWI_XLEN-1:0] o_rdata   // Word at the request of the cycle before
);

  logic [`SWI_XLEN-1:0] mem [`SWI_MEM_WORDS];
  logic [MEM_AW-1:0]    cpu_idx;

  assign cpu_idx = i_req.addr[MEM_AW+1:2];  // Wraps at the memory depth

  always_ff @(posedge i_clk) begin
    if (i_load.stb) begin
      mem[i_load.addr] <= i_load.data;
    end else if (i_req.valid && i_req.write) begin
      mem[cpu_idx] <= i_req.wdata;
    end
    o_rdata <= mem[cpu_idx];
  end

endmodule

//--- hdl/swi_cpu.sv
/* Stack CPU top level. The testbench loads memory while idle,
   pulses i_start and then watches the output strobe and o_halted */
`include "swi_cfg.svh"

module swi_cpu
  import swi_isa_pkg::*;
  import swi_mach_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_arst_n,
  input  swi_load_t            i_load,
  input  logic                 i_start,
  input  logic [`SWI_XLEN-1:0] i_entry_pc,
  output logic                 o_out_stb,
  output logic [7:0]           o_out_data,
  output logic                 o_halted,
  output logic                 o_fault
);

  swi_decoded_t         dec;
  swi_mem_req_t         mem_req;
  logic [`SWI_XLEN-1:0] mem_data, instr, result, addr;
  logic [`SWI_XLEN-1:0] a, b, sp, pc;
  logic                 taken, capture, exec1, exec2;

  swi_decoder u_decoder (.i_instr(instr), .o_dec(dec));

  swi_alu u_alu (
    .i_dec(dec), .i_a(a), .i_b(b), .i_sp(sp), .i_pc(pc), .i_mem_data(mem_data),
    .o_result(result), .o_taken(taken), .o_addr(addr)
  );

  swi_control u_control (
    .i_clk(i_clk), .i_arst_n(i_arst_n), .i_start(i_start), .i_dec(dec),
    .i_addr(addr), .i_pc(pc), .i_a(a), .i_b(b),
    .o_mem_req(mem_req), .o_capture(capture), .o_exec1(exec1), .o_exec2(exec2),
    .o_halted(o_halted), .o_fault(o_fault)
  );

  swi_writeback u_writeback (
    .i_clk(i_clk), .i_arst_n(i_arst_n), .i_start(i_start), .i_entry_pc(i_entry_pc),
    .i_capture(capture), .i_exec1(exec1), .i_exec2(exec2), .i_dec(dec),
    .i_mem_data(mem_data), .i_result(result), .i_taken(taken),
    .o_instr(instr), .o_a(a), .o_b(b), .o_sp(sp), .o_pc(pc),
    .o_out_stb(o_out_stb), .o_out_data(o_out_data)
  );

  swi_ram u_ram (
    .i_clk(i_clk), .i_load(i_load), .i_req(mem_req), .o_rdata(mem_data)
  );

endmodule

//--- tests/swi_checker.sv
/* Scoreboard for the stack CPU. Queues the expected output bytes and halt
   kind from the testbench and compares them with what the DUT puts out */
module swi_checker (
  input  logic       i_clk,
  input  logic       i_out_stb,
  input  logic [7:0] i_out_data,
  input  logic       i_halted,
  input  logic       i_fault,
  input  logic       i_exp_stb,     // Push one expected byte
  input  logic [7:0] i_exp_byte,
  input  logic       i_halt_stb,    // Arm the halt check
  input  logic       i_halt_fault,
  output int         o_errors,
  output int         o_checked
);

  logic [7:0] exp_q[$];
  logic       halt_armed = 1'b0;
  logic       halt_fault = 1'b0;
  logic       halted_q   = 1'b0;   // Edge detect, survives DUT reset

  initial begin
    o_errors  = 0;
    o_checked = 0;
  end

  always @(posedge i_clk) begin
    logic [7:0] want;
    if (i_exp_stb) exp_q.push_back(i_exp_byte);
    if (i_halt_stb) begin
      halt_armed <= 1'b1;
      halt_fault <= i_halt_fault;
    end
    halted_q <= i_halted;

    if (i_out_stb) begin
      if (exp_q.size() == 0) begin
        $display("%0t: output byte %h came with no more bytes expected", $time, i_out_data);
        o_errors++;
      end else begin
        want = exp_q.pop_front();
        o_checked++;
        if (i_out_data !== want) begin
          $display("MISMATCH %0t o_out_data expected %h actual %h", $time, want, i_out_data);
          o_errors++;
        end
      end
    end

    // Halt: fault kind must match and all bytes must have come out
    if (i_halted && !halted_q) begin
      o_checked++;
      if (!halt_armed) begin
        $display("%0t: CPU halted with no halt expected", $time);
        o_errors++;
      end else if (i_fault !== halt_fault) begin
        $display("MISMATCH %0t o_fault expected %b actual %b", $time, halt_fault, i_fault);
        o_errors++;
      end
      if (exp_q.size() != 0) begin
        $display("%0t: %0d expected output bytes never came", $time, exp_q.size());
        o_errors++;
        exp_q.delete();
      end
      halt_armed <= 1'b0;
    end
  end

endmodule

//--- tests/swi_cpu_tb.sv
/* Testbench top for the stack CPU. Reads programs and expected events from the
   tests data file, loads memory, starts each program and waits for the halt */
`include "swi_cfg.svh"

module swi_cpu_tb import swi_mach_pkg::*; ();

  localparam string TEST_FILE = "tests/swi_cpu_tests.txt";

  logic                 clk = 1'b0;
  logic                 arst_n;
  swi_load_t            load;
  logic                 start;
  logic [`SWI_XLEN-1:0] entry_pc;
  logic                 out_stb, halted, fault;
  logic [7:0]           out_data;
  logic                 exp_stb, halt_stb, exp_fault;  // Checker feed
  logic [7:0]           exp_byte;
  int                   errors, checked;
  int                   cycles = 0;
  int                   limit  = 0;    // Zero until the file is scanned
  int                   bad_records = 0;
  int                   tests_run = 0;
  string                lines[$];

  always #20 clk = ~clk;                // Period 40

  swi_cpu uut (
    .i_clk(clk), .i_arst_n(arst_n), .i_load(load), .i_start(start),
    .i_entry_pc(entry_pc), .o_out_stb(out_stb), .o_out_data(out_data),
    .o_halted(halted), .o_fault(fault)
  );

  swi_checker u_checker (
    .i_clk(clk), .i_out_stb(out_stb), .i_out_data(out_data), .i_halted(halted),
    .i_fault(fault), .i_exp_stb(exp_stb), .i_exp_byte(exp_byte),
    .i_halt_stb(halt_stb), .i_halt_fault(exp_fault),
    .o_errors(errors), .o_checked(checked)
  );

  // Run-wide watchdog, limit scales with the loaded program size
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: CPU did not halt within %0d cycles", limit);
      $display("errors=%0d checked=%0d tests=%0d", errors + 1, checked, tests_run);
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic apply_reset();
    arst_n = 1'b0;
    repeat (5) @(posedge clk);
    #2 arst_n = 1'b1;
  endtask

  task automatic load_word(input logic [31:0] idx, input logic [31:0] data);
    @(posedge clk);
    #2;
    load.stb  = 1'b1;
    load.addr = idx[MEM_AW-1:0];   // Word index
    load.data = data;
    @(posedge clk);
    #2 load.stb = 1'b0;
  endtask

  task automatic expect_byte(input logic [7:0] b);
    @(posedge clk);
    #2;
    exp_stb  = 1'b1;
    exp_byte = b;
    @(posedge clk);
    #2 exp_stb = 1'b0;
  endtask

  task automatic expect_halt(input logic f);
    @(posedge clk);
    #2;
    halt_stb  = 1'b1;
    exp_fault = f;
    @(posedge clk);
    #2 halt_stb = 1'b0;
  endtask

  // Start pulse, then wait on o_halted; the watchdog covers a hang
  task automatic run_program(input logic [31:0] pc);
    @(posedge clk);
    #2;
    start    = 1'b1;
    entry_pc = pc;
    @(posedge clk);
    #2 start = 1'b0;
    while (!halted) begin
      @(posedge clk);
      #2;
    end
    repeat (3) @(posedge clk);     // Let stray output reach the checker
    #2;
  endtask

  initial begin
    int          fd;
    int          n_words;
    bit          need_reset;
    bit          open_fail;
    byte         kind;
    string       line;
    string       rest;
    logic [31:0] v1, v2;

    arst_n     = 1'b0;
    load       = '0;
    start      = 1'b0;
    entry_pc   = '0;
    exp_stb    = 1'b0;
    exp_byte   = '0;
    halt_stb   = 1'b0;
    exp_fault  = 1'b0;
    n_words    = 0;
    need_reset = 1'b1;
    open_fail  = 1'b0;

    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      $display("could not open the test data file %s", TEST_FILE);
      open_fail = 1'b1;
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() > 0 && line[0] != "#" && line[0] != "\n" && line[0] != " ") begin
          lines.push_back(line);
          if (line[0] == "L") n_words++;
        end
      end
      $fclose(fd);
    end
    limit = 8 * n_words * 4 + 100;

    foreach (lines[i]) begin
      kind = lines[i][0];
      rest = lines[i].substr(1, lines[i].len() - 1);
      v1   = '0;
      v2   = '0;
      void'($sscanf(rest, "%h %h", v1, v2));
      if (need_reset) begin
        apply_reset();
        need_reset = 1'b0;
      end
      case (kind)
        "L": load_word(v1, v2);
        "O": expect_byte(v1[7:0]);
        "H": expect_halt(v1[0]);
        "S": run_program(v1);
        "E": begin
          need_reset = 1'b1;
          tests_run++;
        end
        default: begin
          $display("unknown record in test data file: %s", lines[i]);
          bad_records++;
        end
      endcase
    end

    $display("errors=%0d checked=%0d tests=%0d bad_records=%0d",
             errors + bad_records + int'(open_fail), checked, tests_run, bad_records);
    if (errors == 0 && bad_records == 0 && !open_fail && tests_run > 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- tests/swi_cpu_tests.txt
# L word_index instruction_word | S entry_byte_pc | O byte | H fault | E end of test
# All values hex; word = imm24 << 8 | opcode
# ALU: immediate forms, MUL, SHR sign fill, SRU, GE, LTU, NE, LHI
L 00 00000523
L 01 00000754
L 02 0000033B
L 03 00000059
L 04 00002B57
L 05 00000175
L 06 0000003E
L 07 0000009A
L 08 00001C78
L 09 00000081
L 0A 0000003E
L 0B 0000009A
L 0C FFFFFF23
L 0D 0000007F
L 0E 0000007C
L 0F 00000672
L 10 0000356C
L 11 00000F6F
L 12 00003E69
L 13 00001224
L 14 00001878
L 15 0000003E
L 16 0000009A
L 17 00000000
O FC
O 01
O 3A
H 0
S 0
E
# Branches taken and untaken, path shown by PUTC order
L 00 00004123
L 01 00000484
L 02 000000F0
L 03 00000486
L 04 000000F0
L 05 0000413B
L 06 00000488
L 07 000000F0
L 08 0000048A
L 09 00000154
L 0A 000000F0
L 0B 0000048C
L 0C 000000F0
L 0D 0000048F
L 0E 000000F0
L 0F 00000403
L 10 000000F0
L 11 00000023
L 12 00000484
L 13 000000F0
L 14 FFFFFF23
L 15 0000048C
L 16 000000F0
L 17 0000048F
L 18 00004323
L 19 000000F0
L 1A 00000000
O 41
O 42
O 42
O 43
H 0
S 0
E
# SL/LL, LBL into B, SG/LG round trips
L 00 00001123
L 01 00000040
L 02 00002223
L 03 FFFFF840
L 04 0000000E
L 05 000000F0
L 06 FFFFF826
L 07 0000009A
L 08 00003323
L 09 00001045
L 0A 00000C15
L 0B 000000F0
L 0C 00000000
L 0E 00000099
O 11
O 22
O 33
H 0
S 0
E
# Push/pop order, JSR into ENT/LEV subroutine
L 00 00000123
L 01 0000009D
L 02 0000029E
L 03 0000033B
L 04 000000A0
L 05 000000A3
L 06 000000F0
L 07 000000A1
L 08 0000009A
L 09 000000A3
L 0A 000000F0
L 0B 00000805
L 0C 000000F0
L 0D 00000000
L 0E FFFFF001
L 0F 00000523
L 10 00001002
O 03
O 02
O 01
O 05
H 0
S 0
E
# Plain HALT
L 00 00004823
L 01 000000F0
L 02 00000000
O 48
H 0
S 0
E
# Unknown opcode halts with fault, later PUTC never runs
L 00 00004923
L 01 000000F0
L 02 000000FF
L 03 000000F0
O 49
H 1
S 0
E

//--- swi_cpu.f
+incdir+hdl
hdl/swi_isa_pkg.sv
hdl/swi_mach_pkg.sv
hdl/swi_decoder.sv
hdl/swi_alu.sv
hdl/swi_control.sv
hdl/swi_writeback.sv
hdl/swi_ram.sv
hdl/swi_cpu.sv
tests/swi_checker.sv
tests/swi_cpu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the stack CPU testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f swi_cpu.f --top-module swi_cpu_tb -o swi_cpu_sim \
  && ./obj_dir/swi_cpu_sim | tee /dev/stderr | grep -q "TESTS PASSED" \
  && echo "simulation run passed" \
  || { echo "simulation run failed"; exit 1; }
